//--- common/mini_core_pkg.sv
`default_nettype none

package mini_core_pkg;

    ////////////////////////////////////////
    // Default sizes

    localparam int DEFAULT_INPUT_DEPTH = 4;
    localparam int DEFAULT_RESULT_DEPTH = 8;
    localparam int DEFAULT_RESULT_CREDITS = 2;

    // Cycles from MUL dispatch to its writeback
    localparam int MUL_LATENCY = 3;

    ////////////////////////////////////////
    // Operations and results

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_MUL
    } op_t;

    typedef logic [3:0] id_t;

    // Decoded op as it arrives from upstream
    typedef struct packed {
        op_t op;
        logic [31:0] rs1;
        logic [31:0] rs2;
    } issue_packet_t;

    typedef struct packed {
        logic valid;
        id_t id;
        op_t op;
        logic [31:0] rs1;
        logic [31:0] rs2;
    } unit_issue_t;

    typedef struct packed {
        id_t id;
        logic [31:0] data;
    } result_t;

    typedef struct packed {
        logic valid;
        result_t result;
    } unit_wb_t;

    ////////////////////////////////////////
    // Trace

    typedef struct packed {
        logic alu_op;
        logic mul_op;
        logic input_empty_stall;
        logic hazard_stall;
        logic writeback_stall;
        logic [4:0] num_in_flight;
    } trace_events_t;

    // One enable per event flag, same order as trace_events_t
    typedef struct packed {
        logic alu_op;
        logic mul_op;
        logic input_empty_stall;
        logic hazard_stall;
        logic writeback_stall;
    } trace_mask_t;

endpackage

`default_nettype wire

//--- exec/alu_unit.sv
`default_nettype none

module alu_unit import mini_core_pkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire unit_issue_t issue,
    output unit_wb_t wb
);

    logic [31:0] alu_result;
    logic wb_valid;
    id_t wb_id;
    logic [31:0] wb_data;

    always_comb begin
        case (issue.op)
            OP_SUB: alu_result = issue.rs1 - issue.rs2;
            OP_AND: alu_result = issue.rs1 & issue.rs2;
            OP_XOR: alu_result = issue.rs1 ^ issue.rs2;
            // Add, and anything not meant for this unit
            default: alu_result = issue.rs1 + issue.rs2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= issue.valid;
    end

    always_ff @(posedge clk) begin
        wb_id <= issue.id;
        wb_data <= alu_result;
    end

    assign wb = '{valid: wb_valid, result: '{id: wb_id, data: wb_data}};

endmodule

`default_nettype wire

//--- exec/mul_unit.sv
`default_nettype none

module mul_unit import mini_core_pkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire unit_issue_t issue,
    output unit_wb_t wb
);

    // Low word only: a*b mod 2^32 needs ll + ((lh + hl) << 16)
    logic [31:0] ll_full;
    logic [31:0] lh_full;
    logic [31:0] hl_full;

    logic [MUL_LATENCY-1:0] valid_pipe;
    id_t id_pipe [MUL_LATENCY];

    // Stage 1
    logic [31:0] s1_ll;
    logic [15:0] s1_lh;
    logic [15:0] s1_hl;
    // Stage 2
    logic [31:0] s2_ll;
    logic [15:0] s2_cross;
    // Stage 3
    logic [31:0] s3_product;

    assign ll_full = issue.rs1[15:0] * issue.rs2[15:0];
    assign lh_full = issue.rs1[15:0] * issue.rs2[31:16];
    assign hl_full = issue.rs1[31:16] * issue.rs2[15:0];

    always_ff @(posedge clk) begin
        if (reset)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[MUL_LATENCY-2:0], issue.valid};
    end

    always_ff @(posedge clk) begin
        id_pipe[0] <= issue.id;
        for (int i = 1; i < MUL_LATENCY; i++)
            id_pipe[i] <= id_pipe[i-1];
    end

    always_ff @(posedge clk) begin
        s1_ll <= ll_full;
        s1_lh <= lh_full[15:0];
        s1_hl <= hl_full[15:0];
        s2_ll <= s1_ll;
        s2_cross <= s1_lh + s1_hl;
        s3_product <= s2_ll + {s2_cross, 16'b0};
    end

    assign wb = '{valid: valid_pipe[MUL_LATENCY-1],
                  result: '{id: id_pipe[MUL_LATENCY-1], data: s3_product}};

endmodule

`default_nettype wire

//--- sim/mini_core_checker.sv
`default_nettype none

module mini_core_checker #(
    parameter int RESULT_CREDITS = 2
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic result_valid,
    input wire logic result_credit,
    input wire logic queue_push,
    input wire logic queue_full,
    input wire logic alu_wb_valid,
    input wire logic mul_wb_valid
);

    localparam int CREDIT_W = $clog2(RESULT_CREDITS + 1);

    // Read by the testbench monitor
    int unsigned assertion_failures = 0;

    // Output credits as seen at the ports
    logic [CREDIT_W-1:0] credits_held;

    always_ff @(posedge clk) begin
        if (reset)
            credits_held <= CREDIT_W'(RESULT_CREDITS);
        else if (result_credit && !result_valid)
            credits_held <= credits_held + 1'b1;
        else if (!result_credit && result_valid)
            credits_held <= credits_held - 1'b1;
    end

    // A result only goes out against a held credit
    result_needs_credit: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> credits_held != '0)
    else begin
        $error("result sent while the output credit count is zero");
        assertion_failures++;
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        queue_push |-> !queue_full)
    else begin
        $error("result queue pushed while full");
        assertion_failures++;
    end

    // Issue rule keeps the units apart
    one_writeback_per_cycle: assert property (@(posedge clk) disable iff (reset)
        !(alu_wb_valid && mul_wb_valid))
    else begin
        $error("ALU and MUL wrote back in the same cycle");
        assertion_failures++;
    end

endmodule

bind writeback_arbiter mini_core_checker #(
    .RESULT_CREDITS(RESULT_CREDITS)
) checker_i (
    .clk(clk),
    .reset(reset),
    .result_valid(result_valid),
    .result_credit(result_credit),
    .queue_push(queue_push),
    .queue_full(queue_full),
    .alu_wb_valid(alu_wb.valid),
    .mul_wb_valid(mul_wb.valid)
);

`default_nettype wire

//--- sim/mini_core_tb.sv
`default_nettype none

module mini_core_tb import mini_core_pkg::*; ();

    localparam int INPUT_DEPTH = DEFAULT_INPUT_DEPTH;
    localparam int RESULT_DEPTH = DEFAULT_RESULT_DEPTH;
    localparam int RESULT_CREDITS = DEFAULT_RESULT_CREDITS;
    localparam int TIMEOUT = 400;

    logic clk;
    logic reset;
    logic op_valid;
    issue_packet_t op;
    logic op_credit;
    logic result_valid;
    result_t result;
    logic result_credit;
    logic cfg_write;
    logic [5:0] cfg_wdata;
    logic [5:0] cfg_rdata;
    trace_events_t tr;

    string test_name;
    logic [15:0] op_lfsr = 16'd64;
    logic [15:0] gap_lfsr = 16'd64;
    logic [15:0] id_busy;
    logic [31:0] expected_data [16];
    int ops_sent = 0;
    int credits_seen = 0;
    int results_received = 0;
    int credits_returned = 0;
    int alu_sent;
    int mul_sent;
    int alu_flags;
    int mul_flags;
    int base;
    logic hold_credits = 1'b0;
    logic trace_off = 1'b1;
    logic count_trace = 1'b0;
    trace_mask_t active_mask = '1;

    mini_core #(
        .INPUT_DEPTH(INPUT_DEPTH),
        .RESULT_DEPTH(RESULT_DEPTH),
        .RESULT_CREDITS(RESULT_CREDITS)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // Random source and reference

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            op_lfsr = lfsr_next(op_lfsr);
            value = {value[30:0], op_lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] reference_result(input op_t code, input logic [31:0] a,
                                                     input logic [31:0] b);
        logic [63:0] product;
        product = 64'(a) * 64'(b);
        case (code)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_XOR: return a ^ b;
            default: return product[31:0];
        endcase
    endfunction

    ////////////////////////////////////////
    // Failure reporting and compares

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", test_name, msg);
        stop_on_failure();
    endtask

    task automatic compare_result(input string what, input result_t exp, input result_t act);
        if (act !== exp) begin
            $display("** Error: %s %s expected id %0d data %h actual id %0d data %h",
                     test_name, what, exp.id, exp.data, act.id, act.data);
            stop_on_failure();
        end
    endtask

    task automatic compare_trace(input string what, input trace_events_t exp,
                                 input trace_events_t act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %h actual %h", test_name, what, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic compare_cfg(input string what, input logic [5:0] exp, input logic [5:0] act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %h actual %h", test_name, what, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("** Error: %s %s expected %0d actual %0d", test_name, what, exp, act);
            stop_on_failure();
        end
    endtask

    ////////////////////////////////////////
    // Drivers, all at 2 units after the edge

    task automatic send_op(input op_t code);
        logic [31:0] a;
        logic [31:0] b;
        id_t id;
        int cycles;
        a = random_bits(32);
        b = random_bits(32);
        id = id_t'(ops_sent);
        cycles = 0;
        while (ops_sent - credits_seen >= INPUT_DEPTH) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > TIMEOUT)
                report_failure("no input credit came back before the timeout");
        end
        if (id_busy[id])
            report_failure("next id is still waiting for its result");
        expected_data[id] = reference_result(code, a, b);
        id_busy[id] = 1'b1;
        if (code == OP_MUL)
            mul_sent++;
        else
            alu_sent++;
        op_valid = 1'b1;
        op = '{op: code, rs1: a, rs2: b};
        ops_sent++;
        @(posedge clk);
        #2;
        op_valid = 1'b0;
    endtask

    // Kind 0 is ALU only, 1 is MUL only, anything else a mix
    task automatic send_ops(input int n, input int kind);
        op_t code;
        for (int i = 0; i < n; i++) begin
            case (kind)
                0: code = op_t'(random_bits(2));
                1: code = OP_MUL;
                default: code = random_bits(1) ? OP_MUL : op_t'(random_bits(2));
            endcase
            send_op(code);
        end
    endtask

    task automatic write_cfg(input logic [5:0] value);
        cfg_write = 1'b1;
        cfg_wdata = value;
        @(posedge clk);
        #2;
        cfg_write = 1'b0;
        compare_cfg("cfg readback", value, cfg_rdata);
        // Trace register follows one cycle later
        repeat (2) @(posedge clk);
        #2;
    endtask

    // Checked one unit after the edge, clear of the credit driver
    task automatic wait_drained();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT)
                report_failure("results did not drain before the timeout");
        end while (results_received != ops_sent || credits_returned != results_received);
        #1;
    endtask

    task automatic set_credit_hold(input logic value);
        @(posedge clk);
        #1;
        hold_credits = value;
        #1;
    endtask

    task automatic reset_trace_counts();
        alu_sent = 0;
        mul_sent = 0;
        alu_flags = 0;
        mul_flags = 0;
    endtask

    // Downstream returns one credit per result, with random gaps
    initial begin : credit_return
        result_credit = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            result_credit = 1'b0;
            if (!reset && !hold_credits && results_received > credits_returned) begin
                gap_lfsr = lfsr_next(gap_lfsr);
                if (gap_lfsr[0]) begin
                    result_credit = 1'b1;
                    credits_returned++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Compare process, mid cycle

    always @(negedge clk) begin : monitor
        result_t expected;
        trace_events_t allowed;
        if (!reset) begin
            if (op_credit)
                credits_seen++;
            if (result_valid) begin
                if (!id_busy[result.id])
                    report_failure("result came back for an id with nothing outstanding");
                expected = '{id: result.id, data: expected_data[result.id]};
                compare_result("result", expected, result);
                id_busy[result.id] = 1'b0;
                results_received++;
            end
            allowed = trace_events_t'({tr[9:5] & active_mask, tr[4:0]});
            if (trace_off)
                compare_trace("trace while disabled", '0, tr);
            else
                compare_trace("trace mask", allowed, tr);
            if (count_trace) begin
                alu_flags += tr.alu_op;
                mul_flags += tr.mul_op;
            end
            if (dut_i.writeback_arbiter_block.checker_i.assertion_failures != 0)
                report_failure("an assertion in the writeback checker failed");
        end
    end

    ////////////////////////////////////////
    // Test sequence

    initial begin : sequencer
        reset = 1'b1;
        op_valid = 1'b0;
        op = '0;
        cfg_write = 1'b0;
        cfg_wdata = '0;
        id_busy = '0;
        reset_trace_counts();
        test_name = "reset";
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        compare_cfg("cfg after reset", 6'b011111, cfg_rdata);
        compare_trace("trace after reset", '0, tr);
        check_count("op_credit after reset", 0, op_credit);
        check_count("result_valid after reset", 0, result_valid);

        test_name = "alu_ops";
        send_ops(20, 0);
        wait_drained();

        test_name = "mul_back_to_back";
        send_ops(9, 1);
        wait_drained();

        test_name = "mixed_ops";
        send_ops(40, 2);
        wait_drained();

        // Enough ops to fill both queues
        test_name = "back_pressure";
        set_credit_hold(1'b1);
        base = results_received;
        send_ops(INPUT_DEPTH + RESULT_DEPTH, 2);
        repeat (20) @(posedge clk);
        #2;
        check_count("results while credits held", RESULT_CREDITS, results_received - base);
        set_credit_hold(1'b0);
        wait_drained();

        test_name = "trace_counts";
        trace_off = 1'b0;
        write_cfg(6'b111111);
        reset_trace_counts();
        count_trace = 1'b1;
        send_ops(24, 2);
        wait_drained();
        repeat (2) @(posedge clk);
        #2;
        count_trace = 1'b0;
        check_count("alu_op flags", alu_sent, alu_flags);
        check_count("mul_op flags", mul_sent, mul_flags);
        compare_trace("trace when idle", '{alu_op: 1'b0, mul_op: 1'b0, input_empty_stall: 1'b1,
                      hazard_stall: 1'b0, writeback_stall: 1'b0, num_in_flight: 5'd0}, tr);

        // ALU and input-empty flags masked off
        test_name = "trace_mask";
        write_cfg(6'b101011);
        active_mask = 5'b01011;
        reset_trace_counts();
        count_trace = 1'b1;
        send_ops(24, 2);
        wait_drained();
        repeat (2) @(posedge clk);
        #2;
        count_trace = 1'b0;
        check_count("alu_op flags with mask cleared", 0, alu_flags);
        check_count("mul_op flags", mul_sent, mul_flags);
        compare_trace("masked trace when idle", '0, tr);

        test_name = "trace_disabled";
        write_cfg(6'b001011);
        trace_off = 1'b1;
        send_ops(12, 2);
        wait_drained();

        test_name = "input_credits";
        check_count("op_credit pulses", ops_sent, credits_seen);
        if (dut_i.writeback_arbiter_block.checker_i.assertion_failures == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_failure("an assertion in the writeback checker failed");
        end
    end

endmodule

`default_nettype wire

//--- sources.f
common/mini_core_pkg.sv
src/credit_fifo.sv
src/issue_unit.sv
exec/alu_unit.sv
exec/mul_unit.sv
src/writeback_arbiter.sv
src/trace_config_regs.sv
src/trace_unit.sv
src/mini_core.sv
sim/mini_core_checker.sv
sim/mini_core_tb.sv

//--- src/credit_fifo.sv
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = 4
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic push,
    input wire payload_t push_data,
    input wire logic pop,
    output payload_t pop_data,
    output logic empty,
    output logic full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    // Wrap at DEPTH so non power of two sizes work
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full = (count == CNT_W'(DEPTH));
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // Head shown directly
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/issue_unit.sv
`default_nettype none

module issue_unit import mini_core_pkg::*; #(
    parameter int INPUT_DEPTH = DEFAULT_INPUT_DEPTH,
    parameter int RESULT_DEPTH = DEFAULT_RESULT_DEPTH
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic op_valid,
    input wire issue_packet_t op,
    output logic op_credit,
    output unit_issue_t alu_issue,
    output unit_issue_t mul_issue,
    input wire logic result_sent,
    output logic [4:0] num_in_flight,
    output logic input_empty_stall,
    output logic hazard_stall
);

    issue_packet_t head;
    logic queue_empty;
    logic head_is_mul;
    logic collision;
    logic at_limit;
    logic dispatch;
    id_t next_id;
    logic [4:0] in_flight;
    // Bit 0 is a MUL dispatched last cycle, the top bit two cycles ago
    logic [MUL_LATENCY-2:0] mul_history;

    credit_fifo #(
        .payload_t(issue_packet_t),
        .DEPTH(INPUT_DEPTH)
    ) input_queue (
        .clk(clk),
        .reset(reset),
        .push(op_valid),
        .push_data(op),
        .pop(dispatch),
        .pop_data(head),
        .empty(queue_empty),
        .full()
    );

    ////////////////////////////////////////
    // Dispatch decision

    assign head_is_mul = (head.op == OP_MUL);

    // ALU now would land on the same writeback cycle as that MUL
    assign collision = !head_is_mul && mul_history[MUL_LATENCY-2];
    assign at_limit = (in_flight == 5'(RESULT_DEPTH));
    assign dispatch = !queue_empty && !collision && !at_limit;

    // Credit goes back as the op leaves the queue
    assign op_credit = dispatch;

    assign alu_issue = '{valid: dispatch && !head_is_mul, id: next_id,
                         op: head.op, rs1: head.rs1, rs2: head.rs2};
    assign mul_issue = '{valid: dispatch && head_is_mul, id: next_id,
                         op: head.op, rs1: head.rs1, rs2: head.rs2};

    assign num_in_flight = in_flight;
    assign input_empty_stall = queue_empty;
    assign hazard_stall = !queue_empty && collision;

    ////////////////////////////////////////
    // Ids, in-flight count, MUL history

    always_ff @(posedge clk) begin
        if (reset) begin
            next_id <= '0;
            in_flight <= '0;
            mul_history <= '0;
        end else begin
            if (dispatch)
                next_id <= next_id + 1'b1;
            case ({dispatch, result_sent})
                2'b10: in_flight <= in_flight + 1'b1;
                2'b01: in_flight <= in_flight - 1'b1;
                default: ;
            endcase
            mul_history <= {mul_history[MUL_LATENCY-3:0], mul_issue.valid};
        end
    end

endmodule

`default_nettype wire

//--- src/mini_core.sv
`default_nettype none

module mini_core import mini_core_pkg::*; #(
    parameter int INPUT_DEPTH = DEFAULT_INPUT_DEPTH,
    parameter int RESULT_DEPTH = DEFAULT_RESULT_DEPTH,
    parameter int RESULT_CREDITS = DEFAULT_RESULT_CREDITS
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic op_valid,
    input wire issue_packet_t op,
    output logic op_credit,
    output logic result_valid,
    output result_t result,
    input wire logic result_credit,
    input wire logic cfg_write,
    input wire logic [5:0] cfg_wdata,
    output logic [5:0] cfg_rdata,
    output trace_events_t tr
);

    unit_issue_t alu_issue;
    unit_issue_t mul_issue;
    unit_wb_t alu_wb;
    unit_wb_t mul_wb;
    logic result_sent;
    logic [4:0] num_in_flight;
    logic input_empty_stall;
    logic hazard_stall;
    logic writeback_stall;
    logic trace_enable;
    trace_mask_t trace_mask;

    ////////////////////////////////////////
    // Issue and execution

    issue_unit #(
        .INPUT_DEPTH(INPUT_DEPTH),
        .RESULT_DEPTH(RESULT_DEPTH)
    ) issue_unit_block (.*);

    alu_unit alu_unit_block (.*, .issue(alu_issue), .wb(alu_wb));
    mul_unit mul_unit_block (.*, .issue(mul_issue), .wb(mul_wb));

    ////////////////////////////////////////
    // Writeback

    writeback_arbiter #(
        .RESULT_DEPTH(RESULT_DEPTH),
        .RESULT_CREDITS(RESULT_CREDITS)
    ) writeback_arbiter_block (.*);

    ////////////////////////////////////////
    // Trace

    trace_config_regs trace_config_block (.*);

    trace_unit trace_unit_block (
        .*,
        .alu_issue_valid(alu_issue.valid),
        .mul_issue_valid(mul_issue.valid)
    );

endmodule

`default_nettype wire

//--- src/trace_config_regs.sv
`default_nettype none

module trace_config_regs import mini_core_pkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire logic cfg_write,
    input wire logic [5:0] cfg_wdata,
    output logic [5:0] cfg_rdata,
    output logic trace_enable,
    output trace_mask_t trace_mask
);

    // Bit 5 is the enable, bits 4:0 the event mask
    localparam int ENABLE_BIT = 5;

    always_ff @(posedge clk) begin
        if (reset) begin
            trace_enable <= 1'b0;
            trace_mask <= '1;
        end else if (cfg_write) begin
            trace_enable <= cfg_wdata[ENABLE_BIT];
            trace_mask <= trace_mask_t'(cfg_wdata[ENABLE_BIT-1:0]);
        end
    end

    // Read-back of both registers
    assign cfg_rdata = {trace_enable, trace_mask};

endmodule

`default_nettype wire

//--- src/trace_unit.sv
`default_nettype none

module trace_unit import mini_core_pkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire logic trace_enable,
    input wire trace_mask_t trace_mask,
    input wire logic alu_issue_valid,
    input wire logic mul_issue_valid,
    input wire logic input_empty_stall,
    input wire logic hazard_stall,
    input wire logic writeback_stall,
    input wire logic [4:0] num_in_flight,
    output trace_events_t tr
);

    ////////////////////////////////////////
    // Event register

    always_ff @(posedge clk) begin
        if (reset || !trace_enable) begin
            tr <= '0;
        end else begin
            tr.alu_op <= alu_issue_valid && trace_mask.alu_op;
            tr.mul_op <= mul_issue_valid && trace_mask.mul_op;
            tr.input_empty_stall <= input_empty_stall && trace_mask.input_empty_stall;
            tr.hazard_stall <= hazard_stall && trace_mask.hazard_stall;
            tr.writeback_stall <= writeback_stall && trace_mask.writeback_stall;
            // Count is not masked, only the enable holds it at zero
            tr.num_in_flight <= num_in_flight;
        end
    end

endmodule

`default_nettype wire

//--- src/writeback_arbiter.sv
`default_nettype none

module writeback_arbiter import mini_core_pkg::*; #(
    parameter int RESULT_DEPTH = DEFAULT_RESULT_DEPTH,
    parameter int RESULT_CREDITS = DEFAULT_RESULT_CREDITS
) (
    input wire logic clk,
    input wire logic reset,
    input wire unit_wb_t alu_wb,
    input wire unit_wb_t mul_wb,
    output logic result_valid,
    output result_t result,
    input wire logic result_credit,
    output logic result_sent,
    output logic writeback_stall
);

    localparam int CREDIT_W = $clog2(RESULT_CREDITS + 1);

    logic queue_push;
    result_t push_result;
    logic queue_pop;
    logic queue_empty;
    logic queue_full;
    logic [CREDIT_W-1:0] credit_count;

    // Issue rule keeps the two writebacks on different cycles
    assign queue_push = alu_wb.valid || mul_wb.valid;
    assign push_result = alu_wb.valid ? alu_wb.result : mul_wb.result;

    credit_fifo #(
        .payload_t(result_t),
        .DEPTH(RESULT_DEPTH)
    ) result_queue (
        .clk(clk),
        .reset(reset),
        .push(queue_push),
        .push_data(push_result),
        .pop(queue_pop),
        .pop_data(result),
        .empty(queue_empty),
        .full(queue_full)
    );

    ////////////////////////////////////////
    // Output credits

    assign queue_pop = !queue_empty && (credit_count != '0);
    assign result_valid = queue_pop;
    assign result_sent = queue_pop;
    assign writeback_stall = !queue_empty && (credit_count == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_count <= CREDIT_W'(RESULT_CREDITS);
        end else begin
            case ({result_credit, queue_pop})
                2'b10: credit_count <= credit_count + 1'b1;
                2'b01: credit_count <= credit_count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire
